// File: sim.f
+incdir+.
x86_pkg.sv
x86_decode.sv
x86_alu.sv
x86_regfile.sv
x86_stack_ram.sv
x86_sequencer.sv
x86_core.sv
tb_x86_core.sv

// File: tb_x86_tests.svh
task automatic reset_values();
	test_name = "reset_values";
	@(negedge clock_4);
	compare_state();
	check_flag("busy", 1'b0, busy);
	check_flag("done", 1'b0, done);
	check_word("esp reset", word_t'(stack_depth * 4), esp);
endtask

// one of each kept instruction and an unknown opcode
task automatic instr_latency();
	test_name = "instr_latency";
	exec_instr(encode_imm24(op_mov_eax_imm, 24'h123456), 4'd5);
	exec_instr(encode(op_mov_rm_r, modrm_ebx_eax, 8'h00, 8'h00), 4'd2);
	exec_instr(encode(op_add_rm_r, modrm_eax_ebx, 8'h00, 8'h00), 4'd2);
	exec_instr(encode(op_push_eax, 8'h00, 8'h00, 8'h00), 4'd1);
	exec_instr(encode(op_push_ebx, 8'h00, 8'h00, 8'h00), 4'd1);
	exec_instr(encode(op_push_imm8, 8'h00, 8'hfd, 8'h00), 4'd2);
	exec_instr(encode(op_pop_ebp, 8'h00, 8'h00, 8'h00), 4'd1);
	exec_instr(encode(op_grp1_imm8, modrm_add_esp, 8'h08, 8'h00), 4'd3);
	// open a frame
	exec_instr(encode(op_push_ebp, 8'h00, 8'h00, 8'h00), 4'd1);
	exec_instr(encode(op_mov_rm_r, modrm_ebp_esp, 8'h00, 8'h00), 4'd2);
	exec_instr(encode(op_grp1_imm8, modrm_sub_esp, 8'h08, 8'h00), 4'd3);
	exec_instr(encode(op_mov_rm_r, modrm_ebp_d8, 8'hfc, 8'h00), 4'd3);
	exec_instr(encode(op_mov_r_rm, modrm_ebp_d8, 8'hfc, 8'h00), 4'd3);
	exec_instr(encode(op_grp1_imm8, modrm_cmp_d8, 8'hfc, 8'h11), 4'd4);
	exec_instr(encode(op_test, modrm_eax_eax, 8'h00, 8'h00), 4'd2);
	exec_instr(encode(op_je, 8'h00, 8'h04, 8'h00), 4'd2);
	exec_instr(encode(op_jne, 8'h00, 8'hfa, 8'h00), 4'd2);
	exec_instr(encode(op_jmp, 8'h00, 8'h02, 8'h00), 4'd2);
	exec_instr(encode_imm24(op_call, 24'h000010), 4'd5);
	exec_instr(encode(op_ret, 8'h00, 8'h00, 8'h00), 4'd1);
	exec_instr(encode(op_leave, 8'h00, 8'h00, 8'h00), 4'd1);
	// nop is outside the subset
	exec_instr(encode(8'h90, 8'h00, 8'h00, 8'h00), 4'd1);
endtask

task automatic push_pop_round_trip();
	word_t r1;
	word_t r2;
	word_t imm;
	word_t esp_start;
	test_name = "push_pop_round_trip";
	take_bits(24, r1);
	take_bits(24, r2);
	take_bits(8, imm);
	esp_start = m_esp;
	exec_instr(encode_imm24(op_mov_eax_imm, r1[23:0]), 4'd5);
	exec_instr(encode(op_mov_rm_r, modrm_ebx_eax, 8'h00, 8'h00), 4'd2);
	exec_instr(encode_imm24(op_mov_eax_imm, r2[23:0]), 4'd5);
	exec_instr(encode(op_push_eax, 8'h00, 8'h00, 8'h00), 4'd1);
	exec_instr(encode(op_push_ebx, 8'h00, 8'h00, 8'h00), 4'd1);
	exec_instr(encode(op_push_imm8, 8'h00, imm[7:0], 8'h00), 4'd2);
	// last in, first out
	exec_instr(encode(op_pop_ebp, 8'h00, 8'h00, 8'h00), 4'd1);
	check_word("first pop", {{24{imm[7]}}, imm[7:0]}, ebp);
	exec_instr(encode(op_pop_ebp, 8'h00, 8'h00, 8'h00), 4'd1);
	check_word("second pop", {8'h00, r1[23:0]}, ebp);
	exec_instr(encode(op_pop_ebp, 8'h00, 8'h00, 8'h00), 4'd1);
	check_word("third pop", {8'h00, r2[23:0]}, ebp);
	check_word("esp after pops", esp_start, esp);
endtask

task automatic frame_access();
	word_t r1;
	word_t r2;
	word_t r3;
	word_t pick;
	logic [7:0] d8;
	test_name = "frame_access";
	take_bits(24, r1);
	take_bits(24, r2);
	take_bits(24, r3);
	take_bits(2, pick);
	// one of the four words below ebp
	d8 = 8'(0 - 4 * (int'(pick[1:0]) + 1));
	exec_instr(encode(op_mov_rm_r, modrm_ebp_esp, 8'h00, 8'h00), 4'd2);
	exec_instr(encode(op_grp1_imm8, modrm_sub_esp, 8'h10, 8'h00), 4'd3);
	exec_instr(encode_imm24(op_mov_eax_imm, r1[23:0]), 4'd5);
	exec_instr(encode(op_mov_rm_r, modrm_ebx_eax, 8'h00, 8'h00), 4'd2);
	exec_instr(encode_imm24(op_mov_eax_imm, r2[23:0]), 4'd5);
	exec_instr(encode(op_add_rm_r, modrm_eax_ebx, 8'h00, 8'h00), 4'd2);
	exec_instr(encode(op_mov_rm_r, modrm_ebp_d8, d8, 8'h00), 4'd3);
	exec_instr(encode_imm24(op_mov_eax_imm, r3[23:0]), 4'd5);
	exec_instr(encode(op_mov_r_rm, modrm_ebp_d8, d8, 8'h00), 4'd3);
	check_word("eax from frame", {8'h00, r1[23:0]} + {8'h00, r2[23:0]}, eax);
	exec_instr(encode(op_grp1_imm8, modrm_add_esp, 8'h10, 8'h00), 4'd3);
endtask

task automatic flags_and_branches();
	word_t k;
	test_name = "flags_and_branches";
	take_bits(8, k);
	exec_instr(encode(op_push_imm8, 8'h00, k[7:0], 8'h00), 4'd2);
	exec_instr(encode(op_mov_rm_r, modrm_ebp_esp, 8'h00, 8'h00), 4'd2);
	// equal compare followed by each branch
	exec_instr(encode(op_grp1_imm8, modrm_cmp_d8, 8'h00, k[7:0]), 4'd4);
	check_flag("zf after equal cmp", 1'b1, zf);
	exec_instr(encode(op_je, 8'h00, 8'h06, 8'h00), 4'd2);
	exec_instr(encode(op_jne, 8'h00, 8'hf6, 8'h00), 4'd2);
	exec_instr(encode(op_jmp, 8'h00, 8'hf0, 8'h00), 4'd2);
	// unequal compare
	exec_instr(encode(op_grp1_imm8, modrm_cmp_d8, 8'h00, k[7:0] ^ 8'h01), 4'd4);
	check_flag("zf after unequal cmp", 1'b0, zf);
	exec_instr(encode(op_je, 8'h00, 8'hf8, 8'h00), 4'd2);
	exec_instr(encode(op_jne, 8'h00, 8'h0c, 8'h00), 4'd2);
	exec_instr(encode(op_jmp, 8'h00, 8'h20, 8'h00), 4'd2);
	exec_instr(encode_imm24(op_mov_eax_imm, 24'h000000), 4'd5);
	exec_instr(encode(op_test, modrm_eax_eax, 8'h00, 8'h00), 4'd2);
	check_flag("zf after test of zero", 1'b1, zf);
	exec_instr(encode(op_je, 8'h00, 8'hfc, 8'h00), 4'd2);
	exec_instr(encode(op_jne, 8'h00, 8'h10, 8'h00), 4'd2);
	exec_instr(encode(op_jmp, 8'h00, 8'h08, 8'h00), 4'd2);
	exec_instr(encode_imm24(op_mov_eax_imm, 24'h000005), 4'd5);
	exec_instr(encode(op_test, modrm_eax_eax, 8'h00, 8'h00), 4'd2);
	check_flag("zf after test of nonzero", 1'b0, zf);
	exec_instr(encode(op_je, 8'h00, 8'h14, 8'h00), 4'd2);
	exec_instr(encode(op_jne, 8'h00, 8'he0, 8'h00), 4'd2);
	exec_instr(encode(op_jmp, 8'h00, 8'hf4, 8'h00), 4'd2);
	exec_instr(encode(op_grp1_imm8, modrm_add_esp, 8'h04, 8'h00), 4'd3);
endtask

task automatic call_and_return();
	word_t rel;
	word_t saved;
	word_t call_addr;
	word_t esp_before;
	word_t ebp_before;
	test_name = "call_and_return";
	take_bits(24, rel);
	take_bits(8, saved);
	// caller frame pointer that differs from the new frame
	exec_instr(encode(op_push_imm8, 8'h00, saved[7:0], 8'h00), 4'd2);
	exec_instr(encode(op_pop_ebp, 8'h00, 8'h00, 8'h00), 4'd1);
	esp_before = m_esp;
	ebp_before = sext8(saved[7:0]);
	exec_instr(encode(op_push_ebp, 8'h00, 8'h00, 8'h00), 4'd1);
	exec_instr(encode(op_mov_rm_r, modrm_ebp_esp, 8'h00, 8'h00), 4'd2);
	exec_instr(encode(op_grp1_imm8, modrm_sub_esp, 8'h08, 8'h00), 4'd3);
	call_addr = m_eip;
	exec_instr(encode_imm24(op_call, rel[23:0]), 4'd5);
	check_word("eip after call", call_addr + 32'd5 + sext24(rel[23:0]), eip);
	exec_instr(encode(op_ret, 8'h00, 8'h00, 8'h00), 4'd1);
	check_word("eip after ret", call_addr + 32'd5, eip);
	exec_instr(encode(op_leave, 8'h00, 8'h00, 8'h00), 4'd1);
	check_word("esp after leave", esp_before, esp);
	check_word("ebp after leave", ebp_before, ebp);
endtask

// File: tb_x86_core.sv
`timescale 1ns/1ps

module tb_x86_core;
	import x86_pkg::*;

	localparam int stack_depth = 64;
	// instructions issued over all tests size the watchdog
	localparam int num_instr = 70;
	localparam int watchdog_cycles = num_instr * 10 + 200;

	// modrm bytes used by the tests
	localparam logic [7:0] modrm_ebp_esp = 8'he5;
	localparam logic [7:0] modrm_ebx_eax = 8'hc3;
	localparam logic [7:0] modrm_ebp_d8 = 8'h45;
	localparam logic [7:0] modrm_add_esp = 8'hc4;
	localparam logic [7:0] modrm_sub_esp = 8'hec;
	localparam logic [7:0] modrm_cmp_d8 = 8'h7d;
	localparam logic [7:0] modrm_eax_eax = 8'hc0;
	localparam logic [7:0] modrm_eax_ebx = 8'hd8;

	logic clock_4;
	logic clock_6;
	logic instr_strobe;
	word_t instr;
	logic [len_w-1:0] instr_len;
	logic busy;
	logic done;
	word_t eax;
	word_t ebx;
	word_t esp;
	word_t ebp;
	word_t eip;
	logic zf;

	// reference copy of the architectural state
	word_t m_eax;
	word_t m_ebx;
	word_t m_esp;
	word_t m_ebp;
	word_t m_eip;
	logic m_zf;
	word_t m_stack [stack_depth];

	string test_name;
	word_t lfsr_state;

	x86_core #(
		.STACK_DEPTH (stack_depth)
	) UUT (
		.clock_4      (clock_4),
		.clock_6      (clock_6),
		.instr_strobe (instr_strobe),
		.instr        (instr),
		.instr_len    (instr_len),
		.busy         (busy),
		.done         (done),
		.eax          (eax),
		.ebx          (ebx),
		.esp          (esp),
		.ebp          (ebp),
		.eip          (eip),
		.zf           (zf)
	);

	initial begin
		clock_4 = 1'b0;
		forever #10 clock_4 = ~clock_4;
	end

	// first error stops the run
	task automatic stop_run();
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string what, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("** Error: %s: %s expected %h, actual %h", test_name, what, exp, act);
			stop_run();
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error: %s: %s expected %b, actual %b", test_name, what, exp, act);
			stop_run();
		end
	endtask

	task automatic check_latency(input string what, input int exp, input int act);
		if (act != exp) begin
			$display("** Error: %s: %s expected %0d, actual %0d", test_name, what, exp, act);
			stop_run();
		end
	endtask

	// fibonacci lfsr with taps 32 22 2 1
	function automatic word_t lfsr_step(input word_t s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one step per bit taken
	task automatic take_bits(input int n, output word_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic word_t encode(input logic [7:0] opc, input logic [7:0] b1,
			input logic [7:0] b2, input logic [7:0] b3);
		return {opc, b1, b2, b3};
	endfunction

	// immediate bytes in memory order with the low byte first
	function automatic word_t encode_imm24(input logic [7:0] opc, input logic [23:0] v);
		return {opc, v[7:0], v[15:8], v[23:16]};
	endfunction

	function automatic word_t sext8(input logic [7:0] b);
		return {{24{b[7]}}, b};
	endfunction

	function automatic word_t sext24(input logic [23:0] v);
		return {{8{v[23]}}, v};
	endfunction

	// byte address to stack word wrapping at the depth
	function automatic int slot(input word_t addr);
		return int'((addr >> 2) % stack_depth);
	endfunction

	task automatic model_reset();
		m_eax = '0;
		m_ebx = '0;
		m_esp = word_t'(stack_depth * 4);
		m_ebp = '0;
		m_eip = EIP_RESET;
		m_zf = 1'b0;
	endtask

	// whole instruction at once and its phase count
	task automatic model_exec(input word_t ins, input logic [len_w-1:0] len, output int phases);
		word_t seq;
		word_t d8;
		word_t ea;
		logic [7:0] modrm;
		seq = m_eip + word_t'(len);
		d8 = sext8(ins[15:8]);
		ea = m_ebp + d8;
		modrm = ins[23:16];
		phases = 1;
		// control flow overrides this below
		m_eip = seq;
		case (ins[31:24])
			op_push_ebp, op_push_eax, op_push_ebx, op_push_imm8: begin
				m_esp = m_esp - 32'd4;
				if (ins[31:24] == op_push_ebp) begin
					m_stack[slot(m_esp)] = m_ebp;
				end else if (ins[31:24] == op_push_eax) begin
					m_stack[slot(m_esp)] = m_eax;
				end else if (ins[31:24] == op_push_ebx) begin
					m_stack[slot(m_esp)] = m_ebx;
				end else begin
					m_stack[slot(m_esp)] = d8;
				end
				phases = 2;
			end
			op_pop_ebp: begin
				m_ebp = m_stack[slot(m_esp)];
				m_esp = m_esp + 32'd4;
				phases = 2;
			end
			op_ret: begin
				m_eip = m_stack[slot(m_esp)];
				m_esp = m_esp + 32'd4;
				phases = 2;
			end
			op_call: begin
				m_esp = m_esp - 32'd4;
				m_stack[slot(m_esp)] = seq;
				m_eip = seq + sext24({ins[7:0], ins[15:8], ins[23:16]});
				phases = 3;
			end
			op_leave: begin
				m_esp = m_ebp;
				m_ebp = m_stack[slot(m_esp)];
				m_esp = m_esp + 32'd4;
				phases = 3;
			end
			op_mov_rm_r: begin
				if (modrm == modrm_ebp_esp) begin
					m_ebp = m_esp;
				end else if (modrm == modrm_ebx_eax) begin
					m_ebx = m_eax;
				end else if (modrm == modrm_ebp_d8) begin
					m_stack[slot(ea)] = m_eax;
				end
			end
			op_mov_r_rm: begin
				if (modrm == modrm_ebp_d8) begin
					m_eax = m_stack[slot(ea)];
				end
			end
			op_mov_eax_imm: m_eax = {8'h00, ins[7:0], ins[15:8], ins[23:16]};
			op_grp1_imm8: begin
				if (modrm == modrm_add_esp) begin
					m_esp = m_esp + d8;
				end else if (modrm == modrm_sub_esp) begin
					m_esp = m_esp - d8;
				end else if (modrm == modrm_cmp_d8) begin
					m_zf = (m_stack[slot(ea)] == sext8(ins[7:0]));
				end
			end
			op_test: begin
				if (modrm == modrm_eax_eax) begin
					m_zf = (m_eax == '0);
				end
			end
			op_add_rm_r: begin
				if (modrm == modrm_eax_ebx) begin
					m_eax = m_eax + m_ebx;
				end
			end
			op_je: m_eip = m_zf ? seq + d8 : seq;
			op_jne: m_eip = m_zf ? seq : seq + d8;
			op_jmp: m_eip = seq + d8;
			default: m_eip = seq;
		endcase
	endtask

	task automatic compare_state();
		check_word("eax", m_eax, eax);
		check_word("ebx", m_ebx, ebx);
		check_word("esp", m_esp, esp);
		check_word("ebp", m_ebp, ebp);
		check_word("eip", m_eip, eip);
		check_flag("zf", m_zf, zf);
	endtask

	// strobe one instruction and count edges up to done
	task automatic exec_instr(input word_t ins, input logic [len_w-1:0] len);
		int cycles;
		int exp_phases;
		model_exec(ins, len, exp_phases);
		@(posedge clock_4);
		instr_strobe <= 1'b1;
		instr <= ins;
		instr_len <= len;
		cycles = 0;
		do begin
			@(posedge clock_4);
			instr_strobe <= 1'b0;
			cycles++;
			// sample away from the active edge
			@(negedge clock_4);
			if (!done) begin
				check_flag("busy while executing", 1'b1, busy);
			end
			if (!done && cycles > 8) begin
				$display("%s: no done pulse within 8 cycles of the strobe", test_name);
				stop_run();
			end
		end while (!done);
		check_latency("strobe to done cycles", exp_phases + 1, cycles);
		check_flag("busy with done", 1'b0, busy);
		compare_state();
	endtask

	`include "tb_x86_tests.svh"

	initial begin
		clock_6 = 1'b1;
		instr_strobe = 1'b0;
		instr = '0;
		instr_len = '0;
		lfsr_state = 32'd96460;
		test_name = "reset";
		model_reset();
		repeat (10) @(posedge clock_4);
		clock_6 <= 1'b0;
		reset_values();
		instr_latency();
		push_pop_round_trip();
		frame_access();
		flags_and_branches();
		call_and_return();
		$display("Test passed");
		$finish;
	end

	// catches a core that never returns done
	initial begin
		repeat (watchdog_cycles) @(posedge clock_4);
		$display("watchdog: run still going after %0d cycles, core looks hung", watchdog_cycles);
		stop_run();
	end

endmodule

// File: x86_alu.sv
`timescale 1ns/1ps

module x86_alu (
	input  x86_pkg::phase_e            phase,
	input  x86_pkg::alu_op_e           op,
	input  x86_pkg::word_t             ope,
	input  logic [x86_pkg::len_w-1:0]  ope_len,
	input  x86_pkg::word_t             eax,
	input  x86_pkg::word_t             ebx,
	input  x86_pkg::word_t             esp,
	input  x86_pkg::word_t             ebp,
	input  x86_pkg::word_t             eip,
	input  logic                       zf,
	input  x86_pkg::word_t             mem_rdata,
	output x86_pkg::word_t             result,
	output x86_pkg::dest_e             dest,
	output x86_pkg::word_t             next_eip,
	output logic                       eip_we,
	output logic                       zf_next,
	output logic                       zf_we,
	output x86_pkg::word_t             mem_addr,
	output x86_pkg::word_t             mem_wdata,
	output logic                       mem_we
);
	import x86_pkg::*;

	word_t disp8;
	word_t cmp_imm;
	word_t imm24;
	word_t rel24;
	word_t eip_seq;
	word_t ebp_disp;

	// d8, imm8 and rel8 sit sign-extended in 15..8
	assign disp8 = {{24{ope[15]}}, ope[15:8]};
	// cmp carries its imm8 behind the d8
	assign cmp_imm = {{24{ope[7]}}, ope[7:0]};
	// low three bytes with the first byte least significant
	assign imm24 = {8'h00, ope[7:0], ope[15:8], ope[23:16]};
	assign rel24 = {{8{ope[7]}}, ope[7:0], ope[15:8], ope[23:16]};
	// address of the following instruction
	assign eip_seq = eip + word_t'(ope_len);
	assign ebp_disp = ebp + disp8;

	always_comb begin
		result = '0;
		dest = dst_none;
		next_eip = eip_seq;
		eip_we = 1'b0;
		zf_next = zf;
		zf_we = 1'b0;
		// esp is the read address unless a frame slot is named
		mem_addr = esp;
		mem_wdata = '0;
		mem_we = 1'b0;
		// idle keeps the defaults and writes nothing
		case (phase)
			ph_a: begin
				case (op)
					alu_push_ebp, alu_push_eax, alu_push_ebx, alu_push_imm8, alu_call: begin
						// make room for one word
						result = esp - 32'd4;
						dest = dst_esp;
					end
					alu_pop_ebp: begin
						result = mem_rdata;
						dest = dst_ebp;
					end
					alu_ret: begin
						// return address from the top of stack
						result = mem_rdata;
						dest = dst_eip;
					end
					alu_leave: begin
						result = ebp;
						dest = dst_esp;
					end
					alu_mov_ebp_esp: begin
						result = esp;
						dest = dst_ebp;
						eip_we = 1'b1;
					end
					alu_mov_ebx_eax: begin
						result = eax;
						dest = dst_ebx;
						eip_we = 1'b1;
					end
					alu_mov_mem_eax: begin
						mem_addr = ebp_disp;
						mem_wdata = eax;
						mem_we = 1'b1;
						eip_we = 1'b1;
					end
					alu_mov_eax_mem: begin
						mem_addr = ebp_disp;
						result = mem_rdata;
						dest = dst_eax;
						eip_we = 1'b1;
					end
					alu_mov_eax_imm: begin
						result = imm24;
						dest = dst_eax;
						eip_we = 1'b1;
					end
					alu_add_esp: begin
						result = esp + disp8;
						dest = dst_esp;
						eip_we = 1'b1;
					end
					alu_sub_esp: begin
						result = esp - disp8;
						dest = dst_esp;
						eip_we = 1'b1;
					end
					alu_cmp_mem_imm: begin
						mem_addr = ebp_disp;
						zf_next = (mem_rdata == cmp_imm);
						zf_we = 1'b1;
						eip_we = 1'b1;
					end
					alu_test: begin
						// eax & eax is zero only when eax is
						zf_next = (eax == '0);
						zf_we = 1'b1;
						eip_we = 1'b1;
					end
					alu_add_eax_ebx: begin
						result = eax + ebx;
						dest = dst_eax;
						eip_we = 1'b1;
					end
					alu_je: begin
						next_eip = zf ? eip_seq + disp8 : eip_seq;
						eip_we = 1'b1;
					end
					alu_jne: begin
						next_eip = zf ? eip_seq : eip_seq + disp8;
						eip_we = 1'b1;
					end
					alu_jmp: begin
						next_eip = eip_seq + disp8;
						eip_we = 1'b1;
					end
					// nop and unknown opcodes only step eip
					default: eip_we = 1'b1;
				endcase
			end
			ph_b: begin
				case (op)
					alu_push_ebp, alu_push_eax, alu_push_ebx, alu_push_imm8: begin
						// esp already lowered in phase a
						mem_we = 1'b1;
						eip_we = 1'b1;
						if (op == alu_push_ebp) begin
							mem_wdata = ebp;
						end else if (op == alu_push_eax) begin
							mem_wdata = eax;
						end else if (op == alu_push_ebx) begin
							mem_wdata = ebx;
						end else begin
							mem_wdata = disp8;
						end
					end
					alu_pop_ebp: begin
						result = esp + 32'd4;
						dest = dst_esp;
						eip_we = 1'b1;
					end
					alu_ret: begin
						// eip came from the stack and does not advance
						result = esp + 32'd4;
						dest = dst_esp;
					end
					alu_call: begin
						// return address is the next instruction
						mem_wdata = eip_seq;
						mem_we = 1'b1;
					end
					alu_leave: begin
						result = mem_rdata;
						dest = dst_ebp;
					end
					default: result = '0;
				endcase
			end
			ph_c: begin
				case (op)
					alu_call: begin
						next_eip = eip_seq + rel24;
						eip_we = 1'b1;
					end
					alu_leave: begin
						result = esp + 32'd4;
						dest = dst_esp;
						eip_we = 1'b1;
					end
					default: result = '0;
				endcase
			end
		endcase
	end

	// sampled as each phase ends
	// a phase writes a register or the ram but never both
	a_one_target: assert property (@(phase)
		(dest != dst_none) |-> !mem_we);

endmodule

// File: x86_core.sv
`timescale 1ns/1ps

module x86_core #(
	parameter int STACK_DEPTH = 64
) (
	input  logic                       clock_4,
	input  logic                       clock_6,
	input  logic                       instr_strobe,
	input  x86_pkg::word_t             instr,
	input  logic [x86_pkg::len_w-1:0]  instr_len,
	output logic                       busy,
	output logic                       done,
	output x86_pkg::word_t             eax,
	output x86_pkg::word_t             ebx,
	output x86_pkg::word_t             esp,
	output x86_pkg::word_t             ebp,
	output x86_pkg::word_t             eip,
	output logic                       zf
);
	import x86_pkg::*;

	// sequencer to decoder and alu
	phase_e phase;
	word_t ope;
	logic [len_w-1:0] ope_len;
	logic [1:0] phase_count;
	alu_op_e op;

	// alu to register file
	word_t result;
	dest_e dest;
	word_t next_eip;
	logic eip_we;
	logic zf_next;
	logic zf_we;

	// alu to stack ram
	word_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;
	logic mem_we;

	x86_sequencer u_sequencer (
		.clock_4      (clock_4),
		.clock_6      (clock_6),
		.instr_strobe (instr_strobe),
		.instr        (instr),
		.instr_len    (instr_len),
		.phase_count  (phase_count),
		.phase        (phase),
		.ope          (ope),
		.ope_len      (ope_len),
		.busy         (busy),
		.done         (done)
	);

	// decode from the held instruction
	x86_decode u_decode (
		.opcode      (ope[31:24]),
		.modrm       (ope[23:16]),
		.op          (op),
		.phase_count (phase_count)
	);

	x86_alu u_alu (
		.phase     (phase),
		.op        (op),
		.ope       (ope),
		.ope_len   (ope_len),
		.eax       (eax),
		.ebx       (ebx),
		.esp       (esp),
		.ebp       (ebp),
		.eip       (eip),
		.zf        (zf),
		.mem_rdata (mem_rdata),
		.result    (result),
		.dest      (dest),
		.next_eip  (next_eip),
		.eip_we    (eip_we),
		.zf_next   (zf_next),
		.zf_we     (zf_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_we    (mem_we)
	);

	x86_regfile #(
		.STACK_DEPTH (STACK_DEPTH)
	) u_regfile (
		.clock_4  (clock_4),
		.clock_6  (clock_6),
		.result   (result),
		.dest     (dest),
		.next_eip (next_eip),
		.eip_we   (eip_we),
		.zf_next  (zf_next),
		.zf_we    (zf_we),
		.eax      (eax),
		.ebx      (ebx),
		.esp      (esp),
		.ebp      (ebp),
		.eip      (eip),
		.zf       (zf)
	);

	x86_stack_ram #(
		.STACK_DEPTH (STACK_DEPTH)
	) u_stack_ram (
		.clock_4   (clock_4),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_we    (mem_we),
		.mem_rdata (mem_rdata)
	);

endmodule

// File: x86_decode.sv
`timescale 1ns/1ps

module x86_decode (
	input  logic [7:0]        opcode,
	input  logic [7:0]        modrm,
	output x86_pkg::alu_op_e  op,
	output logic [1:0]        phase_count
);
	import x86_pkg::*;

	// modrm bytes of the register and memory forms
	localparam logic [7:0] rm_ebp_esp = 8'he5;
	localparam logic [7:0] rm_ebx_eax = 8'hc3;
	localparam logic [7:0] rm_ebp_d8 = 8'h45;
	localparam logic [7:0] rm_add_esp = 8'hc4;
	localparam logic [7:0] rm_sub_esp = 8'hec;
	localparam logic [7:0] rm_cmp_d8 = 8'h7d;
	localparam logic [7:0] rm_eax_eax = 8'hc0;
	localparam logic [7:0] rm_eax_ebx = 8'hd8;

	// opcode plus modrm to operation
	always_comb begin
		op = alu_nop;
		case (opcode_e'(opcode))
			op_push_ebp:    op = alu_push_ebp;
			op_push_eax:    op = alu_push_eax;
			op_push_ebx:    op = alu_push_ebx;
			op_push_imm8:   op = alu_push_imm8;
			op_pop_ebp:     op = alu_pop_ebp;
			op_mov_eax_imm: op = alu_mov_eax_imm;
			op_je:          op = alu_je;
			op_jne:         op = alu_jne;
			op_jmp:         op = alu_jmp;
			op_call:        op = alu_call;
			op_ret:         op = alu_ret;
			op_leave:       op = alu_leave;
			op_mov_rm_r: begin
				// mov ebp,esp / mov ebx,eax / mov [ebp+d8],eax
				if (modrm == rm_ebp_esp) begin
					op = alu_mov_ebp_esp;
				end else if (modrm == rm_ebx_eax) begin
					op = alu_mov_ebx_eax;
				end else if (modrm == rm_ebp_d8) begin
					op = alu_mov_mem_eax;
				end
			end
			op_mov_r_rm: begin
				if (modrm == rm_ebp_d8) begin
					op = alu_mov_eax_mem;
				end
			end
			op_grp1_imm8: begin
				// /0 add, /5 sub, /7 cmp
				if (modrm == rm_add_esp) begin
					op = alu_add_esp;
				end else if (modrm == rm_sub_esp) begin
					op = alu_sub_esp;
				end else if (modrm == rm_cmp_d8) begin
					op = alu_cmp_mem_imm;
				end
			end
			op_test: begin
				if (modrm == rm_eax_eax) begin
					op = alu_test;
				end
			end
			op_add_rm_r: begin
				if (modrm == rm_eax_ebx) begin
					op = alu_add_eax_ebx;
				end
			end
			default: op = alu_nop;
		endcase
	end

	// stack traffic needs extra phases
	always_comb begin
		case (op)
			alu_push_ebp, alu_push_eax, alu_push_ebx, alu_push_imm8: phase_count = 2'd2;
			alu_pop_ebp, alu_ret: phase_count = 2'd2;
			alu_call, alu_leave:  phase_count = 2'd3;
			default:              phase_count = 2'd1;
		endcase
	end

endmodule

// File: x86_pkg.sv
package x86_pkg;

	// data word and instruction length widths
	localparam int word_w = 32;
	localparam int len_w = 4;

	typedef logic [word_w-1:0] word_t;

	// eip after reset
	localparam word_t EIP_RESET = 32'h0000_0000;

	// first byte of each kept instruction
	typedef enum logic [7:0] {
		op_add_rm_r    = 8'h01,
		op_push_eax    = 8'h50,
		op_push_ebx    = 8'h53,
		op_push_ebp    = 8'h55,
		op_pop_ebp     = 8'h5d,
		op_push_imm8   = 8'h6a,
		op_je          = 8'h74,
		op_jne         = 8'h75,
		// add, sub and cmp share 83, told apart by modrm
		op_grp1_imm8   = 8'h83,
		op_test        = 8'h85,
		op_mov_rm_r    = 8'h89,
		op_mov_r_rm    = 8'h8b,
		op_mov_eax_imm = 8'hb8,
		op_ret         = 8'hc3,
		op_leave       = 8'hc9,
		op_call        = 8'he8,
		op_jmp         = 8'heb
	} opcode_e;

	// one operation per kept instruction form
	typedef enum logic [4:0] {
		alu_nop,
		alu_push_ebp,
		alu_push_eax,
		alu_push_ebx,
		alu_push_imm8,
		alu_pop_ebp,
		alu_mov_ebp_esp,
		alu_mov_ebx_eax,
		alu_mov_mem_eax,
		alu_mov_eax_mem,
		alu_mov_eax_imm,
		alu_add_esp,
		alu_sub_esp,
		alu_cmp_mem_imm,
		alu_test,
		alu_add_eax_ebx,
		alu_je,
		alu_jne,
		alu_jmp,
		alu_call,
		alu_ret,
		alu_leave
	} alu_op_e;

	// execution phases, up to three per instruction
	typedef enum logic [1:0] {
		ph_idle,
		ph_a,
		ph_b,
		ph_c
	} phase_e;

	// register written by result in a phase
	typedef enum logic [2:0] {
		dst_none,
		dst_eax,
		dst_ebx,
		dst_esp,
		dst_ebp,
		dst_eip
	} dest_e;

endpackage

// File: x86_regfile.sv
`timescale 1ns/1ps

module x86_regfile #(
	parameter int STACK_DEPTH = 64
) (
	input  logic            clock_4,
	input  logic            clock_6,
	input  x86_pkg::word_t  result,
	input  x86_pkg::dest_e  dest,
	input  x86_pkg::word_t  next_eip,
	input  logic            eip_we,
	input  logic            zf_next,
	input  logic            zf_we,
	output x86_pkg::word_t  eax,
	output x86_pkg::word_t  ebx,
	output x86_pkg::word_t  esp,
	output x86_pkg::word_t  ebp,
	output x86_pkg::word_t  eip,
	output logic            zf
);
	import x86_pkg::*;

	// empty stack points one word past the last ram entry
	localparam word_t esp_reset = word_t'(STACK_DEPTH * 4);

	// general registers, one write per cycle through dest
	always_ff @(posedge clock_4 or posedge clock_6) begin
		if (clock_6) begin
			eax <= '0;
			ebx <= '0;
			esp <= esp_reset;
			ebp <= '0;
		end else begin
			case (dest)
				dst_eax: eax <= result;
				dst_ebx: ebx <= result;
				dst_esp: esp <= result;
				dst_ebp: ebp <= result;
				default: ;
			endcase
		end
	end

	// eip has two sources
	always_ff @(posedge clock_4 or posedge clock_6) begin
		if (clock_6) begin
			eip <= EIP_RESET;
		end else if (dest == dst_eip) begin
			// ret loads eip from the stack, beats the advance
			eip <= result;
		end else if (eip_we) begin
			eip <= next_eip;
		end
	end

	// only cmp and test touch the flag
	always_ff @(posedge clock_4 or posedge clock_6) begin
		if (clock_6) begin
			zf <= 1'b0;
		end else if (zf_we) begin
			zf <= zf_next;
		end
	end

endmodule

// File: x86_sequencer.sv
`timescale 1ns/1ps

module x86_sequencer (
	input  logic                       clock_4,
	input  logic                       clock_6,
	input  logic                       instr_strobe,
	input  x86_pkg::word_t             instr,
	input  logic [x86_pkg::len_w-1:0]  instr_len,
	input  logic [1:0]                 phase_count,
	output x86_pkg::phase_e            phase,
	output x86_pkg::word_t             ope,
	output logic [x86_pkg::len_w-1:0]  ope_len,
	output logic                       busy,
	output logic                       done
);
	import x86_pkg::*;

	phase_e phase_nxt;
	logic last_phase;

	// phase number reaching the count ends the instruction
	always_comb begin
		case (phase)
			ph_a:    last_phase = (phase_count <= 2'd1);
			ph_b:    last_phase = (phase_count <= 2'd2);
			ph_c:    last_phase = 1'b1;
			default: last_phase = 1'b0;
		endcase
	end

	// idle -> a -> b -> c, cut short by the count
	always_comb begin
		phase_nxt = phase;
		if (phase == ph_idle) begin
			if (instr_strobe) begin
				phase_nxt = ph_a;
			end
		end else if (last_phase) begin
			phase_nxt = ph_idle;
		end else if (phase == ph_a) begin
			phase_nxt = ph_b;
		end else begin
			phase_nxt = ph_c;
		end
	end

	always_ff @(posedge clock_4 or posedge clock_6) begin
		if (clock_6) begin
			phase <= ph_idle;
			done <= 1'b0;
		end else begin
			phase <= phase_nxt;
			// pulse after the last phase's write
			done <= last_phase;
		end
	end

	// instruction held for all its phases
	always_ff @(posedge clock_4) begin
		if (instr_strobe && !busy) begin
			ope <= instr;
			ope_len <= instr_len;
		end
	end

	// drops together with the done pulse
	assign busy = (phase != ph_idle);

	// no back-pressure, a strobe mid-instruction is lost
	a_no_strobe_busy: assert property (@(posedge clock_4) disable iff (clock_6)
		instr_strobe |-> !busy);

	a_done_pulse: assert property (@(posedge clock_4) disable iff (clock_6)
		done |=> !done);

endmodule

// File: x86_stack_ram.sv
`timescale 1ns/1ps

module x86_stack_ram #(
	parameter int STACK_DEPTH = 64
) (
	input  logic            clock_4,
	input  x86_pkg::word_t  mem_addr,
	input  x86_pkg::word_t  mem_wdata,
	input  logic            mem_we,
	output x86_pkg::word_t  mem_rdata
);
	import x86_pkg::*;

	localparam int addr_w = $clog2(STACK_DEPTH);

	word_t mem [STACK_DEPTH];
	logic [addr_w-1:0] word_idx;

	// index wraps at the depth
	if ((STACK_DEPTH & (STACK_DEPTH - 1)) != 0) begin : g_depth_check
		$error("x86_stack_ram: STACK_DEPTH must be a power of two");
	end

	// byte address to word index, low two bits dropped
	assign word_idx = mem_addr[addr_w+1:2];

	// read is combinational
	// pop and ret use it in the same phase
	assign mem_rdata = mem[word_idx];

	// write on the phase edge
	always_ff @(posedge clock_4) begin
		if (mem_we) begin
			mem[word_idx] <= mem_wdata;
		end
	end

	// esp steps by 4 and frame offsets are multiples of 4
	a_word_aligned: assert property (@(posedge clock_4)
		!$isunknown(mem_addr) |-> (mem_addr[1:0] == 2'b00));

endmodule
